// File: quasi_bus_pkg.sv
/* shared bus widths, memory map constants and the address word layout
   imported by the fabric modules, the bus interface and the top level */
`default_nettype none

package quasi_bus_pkg;

	// bus widths
	localparam int data_w = 32;
	localparam int addr_w = 32;

	// memory depths as log2 of the word count
	localparam int main_depth_log2 = 12;
	localparam int scratch_depth_log2 = 10;
	localparam int boot_depth_log2 = 4;

	// device field codes in the I/O region, 3 to 15 unmapped
	localparam logic [3:0] dev_boot = 4'd0;
	localparam logic [3:0] dev_scratch = 4'd1;
	localparam logic [3:0] dev_gpio = 4'd2;

	// gpio word offsets
	localparam logic [17:0] gpio_led_off = 18'd0;
	localparam logic [17:0] gpio_in_off = 18'd1;

	localparam string boot_image = "boot_rom.hex";

	// region 1 is main memory, region 0 is I/O
	typedef union packed {
		struct packed {
			logic region;
			logic [28:0] index;
			logic [1:0] byte_off;
		} mem_view;
		struct packed {
			logic region;
			logic [6:0] rsvd;
			logic [3:0] dev;
			logic [17:0] offset;
			logic [1:0] byte_off;
		} mmio_view;
	} bus_addr_u;

endpackage

`default_nettype wire

// File: mem_bus_if.sv
/* one word bus segment between a host and a device
   hosts hold a and d stable from the rd or we strobe until ready */
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if import quasi_bus_pkg::*; ();

	bus_addr_u a;
	logic [data_w-1:0] d;
	logic we;
	logic rd;
	logic [data_w-1:0] spo;
	logic ready;

	modport host (
		output a, d, we, rd,
		input spo, ready
	);

	modport device (
		input a, d, we, rd,
		output spo, ready
	);

endinterface

`default_nettype wire

// File: bus_arbiter.sv
/* two host arbiter for the shared word bus, host 0 has priority
   a host keeps the bus from gnt until it drops req */
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter import quasi_bus_pkg::*; (
	input logic clk_mem,
	input logic rst_n,
	input logic req0,
	input logic req1,
	output logic gnt0,
	output logic gnt1,
	input logic [addr_w-1:0] h0_a,
	input logic [data_w-1:0] h0_d,
	input logic h0_we,
	input logic h0_rd,
	output logic [data_w-1:0] h0_spo,
	output logic h0_ready,
	input logic [addr_w-1:0] h1_a,
	input logic [data_w-1:0] h1_d,
	input logic h1_we,
	input logic h1_rd,
	output logic [data_w-1:0] h1_spo,
	output logic h1_ready,
	mem_bus_if.host bus
);

	// owner[0] is host 0, owner[1] is host 1, both low when idle
	logic [1:0] owner;

	always_ff @(posedge clk_mem or negedge rst_n) begin
		if (!rst_n) begin
			owner <= 2'b00;
		end else begin
			case (owner)
				2'b01: if (!req0) owner <= 2'b00;
				2'b10: if (!req1) owner <= 2'b00;
				default: begin
					// fixed priority on an idle bus
					if (req0)
						owner <= 2'b01;
					else if (req1)
						owner <= 2'b10;
					else
						owner <= 2'b00;
				end
			endcase
		end
	end

	assign gnt0 = owner[0];
	assign gnt1 = owner[1];

	// strobes from a host without grant never reach the bus
	assign bus.a = owner[1] ? h1_a : h0_a;
	assign bus.d = owner[1] ? h1_d : h0_d;
	assign bus.we = (owner[0] & h0_we) | (owner[1] & h1_we);
	assign bus.rd = (owner[0] & h0_rd) | (owner[1] & h1_rd);

	assign h0_spo = owner[0] ? bus.spo : '0;
	assign h0_ready = owner[0] & bus.ready;
	assign h1_spo = owner[1] ? bus.spo : '0;
	assign h1_ready = owner[1] & bus.ready;

endmodule

`default_nettype wire

// File: region_splitter.sv
/* high address decode of the shared bus into main memory or I/O
   purely combinational, the region bit picks one side per access */
`timescale 1ns/100ps
`default_nettype none

module region_splitter (
	mem_bus_if.device up,
	mem_bus_if.host mem,
	mem_bus_if.host mmio
);

	logic to_mem;

	assign to_mem = up.a.mem_view.region;

	// address and data fan out to both sides
	assign mem.a = up.a;
	assign mem.d = up.d;
	assign mmio.a = up.a;
	assign mmio.d = up.d;

	// only the selected side sees strobes
	assign mem.we = up.we & to_mem;
	assign mem.rd = up.rd & to_mem;
	assign mmio.we = up.we & ~to_mem;
	assign mmio.rd = up.rd & ~to_mem;

	// response from whichever side the held address selects
	assign up.spo = to_mem ? mem.spo : mmio.spo;
	assign up.ready = to_mem ? mem.ready : mmio.ready;

endmodule

`default_nettype wire

// File: mmio_decoder.sv
/* I/O region decode into boot ROM, scratch RAM and GPIO by device field
   unmapped device codes read zero and acknowledge in the same cycle */
`timescale 1ns/100ps
`default_nettype none

module mmio_decoder import quasi_bus_pkg::*; (
	mem_bus_if.device up,
	mem_bus_if.host boot,
	mem_bus_if.host scratch,
	mem_bus_if.host gpio
);

	logic [3:0] dev;

	assign dev = up.a.mmio_view.dev;

	assign boot.a = up.a;
	assign boot.d = up.d;
	assign scratch.a = up.a;
	assign scratch.d = up.d;
	assign gpio.a = up.a;
	assign gpio.d = up.d;

	always_comb begin
		boot.we = 1'b0;
		boot.rd = 1'b0;
		scratch.we = 1'b0;
		scratch.rd = 1'b0;
		gpio.we = 1'b0;
		gpio.rd = 1'b0;
		up.spo = '0;
		up.ready = 1'b0;
		case (dev)
			dev_boot: begin
				boot.we = up.we;
				boot.rd = up.rd;
				up.spo = boot.spo;
				up.ready = boot.ready;
			end
			dev_scratch: begin
				scratch.we = up.we;
				scratch.rd = up.rd;
				up.spo = scratch.spo;
				up.ready = scratch.ready;
			end
			dev_gpio: begin
				gpio.we = up.we;
				gpio.rd = up.rd;
				up.spo = gpio.spo;
				up.ready = gpio.ready;
			end
			default: begin
				// nothing mapped here, ack right away
				up.ready = up.we | up.rd;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: word_ram.sv
/* single port word RAM with one clock of access latency
   used for main memory and for the scratch RAM */
`timescale 1ns/100ps
`default_nettype none

module word_ram import quasi_bus_pkg::*; #(
	parameter int depth_log2 = main_depth_log2
) (
	input logic clk_mem,
	input logic rst_n,
	mem_bus_if.device bus
);

	logic [data_w-1:0] mem [0:(2**depth_log2)-1];
	logic [depth_log2-1:0] idx;
	logic [data_w-1:0] rdata;
	logic ready_q;

	// upper index bits ignored, so the memory aliases
	assign idx = bus.a.mem_view.index[depth_log2-1:0];

	always_ff @(posedge clk_mem) begin
		if (bus.we)
			mem[idx] <= bus.d;
		if (bus.rd)
			rdata <= mem[idx];
	end

	// one ack per strobe, a clock later
	always_ff @(posedge clk_mem or negedge rst_n) begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= bus.we | bus.rd;
	end

	assign bus.spo = rdata;
	assign bus.ready = ready_q;

endmodule

`default_nettype wire

// File: boot_rom.sv
/* sixteen word boot ROM loaded from the boot image at start
   reads take one clock, writes are acked and dropped */
`timescale 1ns/100ps
`default_nettype none

module boot_rom import quasi_bus_pkg::*; (
	input logic clk_mem,
	input logic rst_n,
	mem_bus_if.device bus
);

	logic [data_w-1:0] rom [0:(2**boot_depth_log2)-1];
	logic [boot_depth_log2-1:0] idx;
	logic [data_w-1:0] rdata;
	logic ready_q;

	initial begin
		$readmemh(boot_image, rom);
	end

	// word offset wraps every sixteen words
	assign idx = bus.a.mmio_view.offset[boot_depth_log2-1:0];

	always_ff @(posedge clk_mem) begin
		if (bus.rd)
			rdata <= rom[idx];
	end

	always_ff @(posedge clk_mem or negedge rst_n) begin
		if (!rst_n)
			ready_q <= 1'b0;
		else
			ready_q <= bus.we | bus.rd;
	end

	assign bus.spo = rdata;
	assign bus.ready = ready_q;

endmodule

`default_nettype wire

// File: gpio_port.sv
/* LED output register and synchronized switch and button inputs
   accesses complete in the strobe cycle */
`timescale 1ns/100ps
`default_nettype none

module gpio_port import quasi_bus_pkg::*; (
	input logic clk_mem,
	input logic rst_n,
	mem_bus_if.device bus,
	input logic [1:0] sw,
	input logic [1:0] btn,
	output logic [3:0] led
);

	logic [1:0] sw_s1;
	logic [1:0] sw_s2;
	logic [1:0] btn_s1;
	logic [1:0] btn_s2;

	always_ff @(posedge clk_mem or negedge rst_n) begin
		if (!rst_n) begin
			led <= 4'b0;
			sw_s1 <= 2'b0;
			sw_s2 <= 2'b0;
			btn_s1 <= 2'b0;
			btn_s2 <= 2'b0;
		end else begin
			// two flop sync on the board inputs
			sw_s1 <= sw;
			sw_s2 <= sw_s1;
			btn_s1 <= btn;
			btn_s2 <= btn_s1;
			if (bus.we && bus.a.mmio_view.offset == gpio_led_off)
				led <= bus.d[3:0];
		end
	end

	always_comb begin
		case (bus.a.mmio_view.offset)
			gpio_led_off: bus.spo = {{(data_w-4){1'b0}}, led};
			gpio_in_off: bus.spo = {{(data_w-4){1'b0}}, btn_s2, sw_s2};
			default: bus.spo = '0;
		endcase
	end

	assign bus.ready = bus.we | bus.rd;

endmodule

`default_nettype wire

// File: quasi_soc_top.sv
/* memory bus fabric top level with two host ports and the board I/O
   arbiter, region split, I/O decode and the four devices */
`timescale 1ns/100ps
`default_nettype none

module quasi_soc_top import quasi_bus_pkg::*; (
	input logic clk_mem,
	input logic rst_n,
	input logic h0_req,
	output logic h0_gnt,
	input logic [addr_w-1:0] h0_a,
	input logic [data_w-1:0] h0_d,
	input logic h0_we,
	input logic h0_rd,
	output logic [data_w-1:0] h0_spo,
	output logic h0_ready,
	input logic h1_req,
	output logic h1_gnt,
	input logic [addr_w-1:0] h1_a,
	input logic [data_w-1:0] h1_d,
	input logic h1_we,
	input logic h1_rd,
	output logic [data_w-1:0] h1_spo,
	output logic h1_ready,
	input logic [1:0] sw,
	input logic [1:0] btn,
	output logic [3:0] led
);

	mem_bus_if shared_bus ();
	mem_bus_if mem_bus ();
	mem_bus_if mmio_bus ();
	mem_bus_if boot_bus ();
	mem_bus_if scratch_bus ();
	mem_bus_if gpio_bus ();

	bus_arbiter arb_inst (
		.clk_mem(clk_mem), .rst_n(rst_n),
		.req0(h0_req), .gnt0(h0_gnt), .req1(h1_req), .gnt1(h1_gnt),
		.h0_a(h0_a), .h0_d(h0_d), .h0_we(h0_we), .h0_rd(h0_rd),
		.h0_spo(h0_spo), .h0_ready(h0_ready),
		.h1_a(h1_a), .h1_d(h1_d), .h1_we(h1_we), .h1_rd(h1_rd),
		.h1_spo(h1_spo), .h1_ready(h1_ready),
		.bus(shared_bus)
	);

	region_splitter splitter_inst (.up(shared_bus), .mem(mem_bus), .mmio(mmio_bus));

	mmio_decoder decoder_inst (
		.up(mmio_bus), .boot(boot_bus), .scratch(scratch_bus), .gpio(gpio_bus)
	);

	word_ram #(.depth_log2(main_depth_log2)) main_ram (
		.clk_mem(clk_mem), .rst_n(rst_n), .bus(mem_bus)
	);

	word_ram #(.depth_log2(scratch_depth_log2)) scratch_ram (
		.clk_mem(clk_mem), .rst_n(rst_n), .bus(scratch_bus)
	);

	boot_rom boot_rom_inst (.clk_mem(clk_mem), .rst_n(rst_n), .bus(boot_bus));

	gpio_port gpio_inst (
		.clk_mem(clk_mem), .rst_n(rst_n), .bus(gpio_bus),
		.sw(sw), .btn(btn), .led(led)
	);

endmodule

`default_nettype wire

// File: tb_quasi_soc.sv
/* testbench for the memory bus fabric, applies a table of host accesses
   in a loop, then checks arbitration with both hosts requesting together */
`timescale 1ns/100ps
`default_nettype none

module tb_quasi_soc import quasi_bus_pkg::*; ();

	logic clk_mem = 1'b0;
	logic rst_n;
	logic h0_req, h1_req;
	logic h0_gnt, h1_gnt;
	logic [addr_w-1:0] h0_a, h1_a;
	logic [data_w-1:0] h0_d, h1_d;
	logic h0_we, h0_rd, h1_we, h1_rd;
	logic [data_w-1:0] h0_spo, h1_spo;
	logic h0_ready, h1_ready;
	logic [1:0] sw, btn;
	logic [3:0] led;

	// stimulus table, one access or board action per entry
	bit tbl_host[$];
	byte tbl_op[$];
	logic [31:0] tbl_addr[$];
	logic [31:0] tbl_wdata[$];
	logic [31:0] tbl_exp[$];

	logic [31:0] rom_image [0:15];
	logic [31:0] rng_state;
	logic [31:0] saved_main;
	logic [31:0] saved_scratch;
	int cycle_count = 0;
	int cycle_limit;
	bit hold_h1_low = 1'b0;

	quasi_soc_top dut0 (
		.clk_mem(clk_mem), .rst_n(rst_n),
		.h0_req(h0_req), .h0_gnt(h0_gnt), .h0_a(h0_a), .h0_d(h0_d),
		.h0_we(h0_we), .h0_rd(h0_rd), .h0_spo(h0_spo), .h0_ready(h0_ready),
		.h1_req(h1_req), .h1_gnt(h1_gnt), .h1_a(h1_a), .h1_d(h1_d),
		.h1_we(h1_we), .h1_rd(h1_rd), .h1_spo(h1_spo), .h1_ready(h1_ready),
		.sw(sw), .btn(btn), .led(led)
	);

	always #50 clk_mem = ~clk_mem;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp)
		else fail_run($sformatf("FAIL: %s got 0x%08h expected 0x%08h", name, got, exp));
	endtask

	always @(posedge clk_mem) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit)
			fail_run($sformatf("timeout, run not finished after %0d cycles", cycle_count));
	end

	// grant exclusivity, and host 1 kept off while host 0 owns the bus
	always @(negedge clk_mem) begin
		assert (!(h0_gnt && h1_gnt))
		else fail_run("both hosts were granted the bus at the same time");
		if (hold_h1_low)
			check_value("h1_gnt", {31'b0, h1_gnt}, 32'h0);
	end

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [31:0] main_addr(input logic [28:0] idx);
		return {1'b1, idx, 2'b00};
	endfunction

	function automatic logic [31:0] io_addr(input logic [3:0] dev, input logic [17:0] off);
		return {1'b0, 7'b0, dev, off, 2'b00};
	endfunction

	function automatic logic host_gnt(input bit h);
		return h ? h1_gnt : h0_gnt;
	endfunction

	function automatic logic host_ready(input bit h);
		return h ? h1_ready : h0_ready;
	endfunction

	function automatic logic [31:0] host_spo(input bit h);
		return h ? h1_spo : h0_spo;
	endfunction

	task automatic set_req(input bit h, input logic v);
		if (h)
			h1_req <= v;
		else
			h0_req <= v;
	endtask

	task automatic drive_bus(input bit h, input logic [31:0] a, input logic [31:0] d,
			input logic we, input logic rd);
		if (h) begin
			h1_a <= a;
			h1_d <= d;
			h1_we <= we;
			h1_rd <= rd;
		end else begin
			h0_a <= a;
			h0_d <= d;
			h0_we <= we;
			h0_rd <= rd;
		end
	endtask

	task automatic wait_grant(input bit h);
		@(negedge clk_mem);
		while (!host_gnt(h))
			@(negedge clk_mem);
	endtask

	task automatic request(input bit h);
		@(posedge clk_mem);
		set_req(h, 1'b1);
		wait_grant(h);
	endtask

	task automatic release_bus(input bit h);
		@(posedge clk_mem);
		set_req(h, 1'b0);
		@(negedge clk_mem);
		while (host_gnt(h))
			@(negedge clk_mem);
	endtask

	// one-cycle strobe, address and data held until ready
	task automatic access(input bit h, input bit write, input logic [31:0] a,
			input logic [31:0] d, output logic [31:0] rdata);
		bit done;
		done = 1'b0;
		rdata = '0;
		@(posedge clk_mem);
		drive_bus(h, a, d, write, !write);
		while (!done) begin
			@(negedge clk_mem);
			if (host_ready(h)) begin
				done = 1'b1;
				rdata = host_spo(h);
			end
			@(posedge clk_mem);
			drive_bus(h, a, d, 1'b0, 1'b0);
		end
	endtask

	task automatic add_entry(input bit h, input byte op, input logic [31:0] a,
			input logic [31:0] wdata, input logic [31:0] exp);
		tbl_host.push_back(h);
		tbl_op.push_back(op);
		tbl_addr.push_back(a);
		tbl_wdata.push_back(wdata);
		tbl_exp.push_back(exp);
	endtask

	task automatic build_table();
		logic [31:0] r [0:4];
		logic [31:0] s [0:2];
		int k;
		rng_state = 32'd41;
		for (k = 0; k < 5; k++)
			r[k] = next_random();
		for (k = 0; k < 3; k++)
			s[k] = next_random();
		// main memory, index 4108 aliases index 12
		add_entry(0, "W", main_addr(0), r[0], 0);
		add_entry(0, "W", main_addr(3), r[1], 0);
		add_entry(0, "W", main_addr(255), r[2], 0);
		add_entry(0, "W", main_addr(4095), r[3], 0);
		add_entry(0, "W", main_addr(4096 + 12), r[4], 0);
		add_entry(0, "R", main_addr(0), 0, r[0]);
		add_entry(0, "R", main_addr(3), 0, r[1]);
		add_entry(0, "R", main_addr(255), 0, r[2]);
		add_entry(0, "R", main_addr(4095), 0, r[3]);
		add_entry(0, "R", main_addr(12), 0, r[4]);
		// boot ROM repeats every 16 words, writes are dropped
		add_entry(0, "R", io_addr(dev_boot, 0), 0, rom_image[0]);
		add_entry(0, "R", io_addr(dev_boot, 5), 0, rom_image[5]);
		add_entry(0, "R", io_addr(dev_boot, 15), 0, rom_image[15]);
		add_entry(0, "R", io_addr(dev_boot, 17), 0, rom_image[17 % 16]);
		add_entry(0, "R", io_addr(dev_boot, 31), 0, rom_image[31 % 16]);
		add_entry(0, "W", io_addr(dev_boot, 3), ~rom_image[3], 0);
		add_entry(0, "R", io_addr(dev_boot, 3), 0, rom_image[3]);
		// scratch RAM from host 1 at indexes main memory also uses
		add_entry(1, "W", io_addr(dev_scratch, 0), s[0], 0);
		add_entry(1, "W", io_addr(dev_scratch, 3), s[1], 0);
		add_entry(1, "W", io_addr(dev_scratch, 1023), s[2], 0);
		add_entry(1, "R", io_addr(dev_scratch, 0), 0, s[0]);
		add_entry(1, "R", io_addr(dev_scratch, 3), 0, s[1]);
		add_entry(1, "R", io_addr(dev_scratch, 1023), 0, s[2]);
		add_entry(1, "R", io_addr(dev_scratch, 1024 + 3), 0, s[1]);
		add_entry(0, "R", main_addr(0), 0, r[0]);
		add_entry(0, "R", main_addr(3), 0, r[1]);
		add_entry(0, "R", main_addr(255), 0, r[2]);
		// gpio, then one unmapped device
		add_entry(0, "W", io_addr(dev_gpio, 0), 32'h0000_000a, 0);
		add_entry(0, "L", 0, 0, 32'h0000_000a);
		add_entry(0, "R", io_addr(dev_gpio, 0), 0, 32'h0000_000a);
		add_entry(0, "W", io_addr(dev_gpio, 0), 32'hffff_fff3, 0);
		add_entry(0, "R", io_addr(dev_gpio, 0), 0, 32'h0000_0003);
		add_entry(0, "I", 0, 32'h0000_0009, 0);
		add_entry(0, "R", io_addr(dev_gpio, 1), 0, 32'h0000_0009);
		add_entry(1, "R", io_addr(4'd5, 0), 0, 32'h0);
		saved_main = r[1];
		saved_scratch = s[1];
		cycle_limit = 16 + 20 * tbl_op.size() + 200;
	endtask

	initial begin
		int i;
		logic [31:0] rdata;
		rst_n = 1'b0;
		h0_req = 1'b0;
		h1_req = 1'b0;
		h0_a = '0;
		h0_d = '0;
		h0_we = 1'b0;
		h0_rd = 1'b0;
		h1_a = '0;
		h1_d = '0;
		h1_we = 1'b0;
		h1_rd = 1'b0;
		sw = 2'b00;
		btn = 2'b00;
		$readmemh("boot_rom.hex", rom_image);
		build_table();

		repeat (16) @(posedge clk_mem);
		rst_n <= 1'b1;
		@(negedge clk_mem);
		check_value("h0_gnt", {31'b0, h0_gnt}, 32'h0);
		check_value("h1_gnt", {31'b0, h1_gnt}, 32'h0);
		check_value("h0_ready", {31'b0, h0_ready}, 32'h0);
		check_value("h1_ready", {31'b0, h1_ready}, 32'h0);
		check_value("led", {28'b0, led}, 32'h0);

		for (i = 0; i < tbl_op.size(); i++) begin
			case (tbl_op[i])
				"I": begin
					// synchronizer needs two clocks, give it three
					@(posedge clk_mem);
					sw <= tbl_wdata[i][1:0];
					btn <= tbl_wdata[i][3:2];
					repeat (3) @(posedge clk_mem);
				end
				"L": begin
					@(negedge clk_mem);
					check_value("led", {28'b0, led}, tbl_exp[i]);
				end
				default: begin
					request(tbl_host[i]);
					access(tbl_host[i], tbl_op[i] == "W", tbl_addr[i], tbl_wdata[i], rdata);
					release_bus(tbl_host[i]);
					if (tbl_op[i] == "R")
						check_value(tbl_host[i] ? "h1_spo" : "h0_spo", rdata, tbl_exp[i]);
				end
			endcase
		end

		// both hosts request in the same cycle, host 0 wins
		@(posedge clk_mem);
		h0_req <= 1'b1;
		h1_req <= 1'b1;
		hold_h1_low = 1'b1;
		wait_grant(0);
		access(0, 1'b0, main_addr(3), 0, rdata);
		check_value("h0_spo", rdata, saved_main);
		release_bus(0);
		hold_h1_low = 1'b0;
		wait_grant(1);
		access(1, 1'b0, io_addr(dev_scratch, 3), 0, rdata);
		check_value("h1_spo", rdata, saved_scratch);
		release_bus(1);

		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: boot_rom.hex
// boot image for the boot ROM, one 32-bit hex word per line
// line order is the word offset, 0 to 15
00000013
100002b7
0002a303
00628393
0072a023
00430313
fe031ce3
80000537
00052583
00b50023
00150513
fe559ce3
0000006f
deadc0de
a5a5a5a5
0f0f1e1e

// File: list.f
quasi_bus_pkg.sv
mem_bus_if.sv
bus_arbiter.sv
region_splitter.sv
mmio_decoder.sv
word_ram.sv
boot_rom.sv
gpio_port.sv
quasi_soc_top.sv
tb_quasi_soc.sv
